//--- sdcmd.f
sdcmd_pkg.sv
sdcmd_sclk_gen.sv
sdcmd_crc7.sv
sdcmd_cmd_transmitter.sv
sdcmd_top.sv
sdcmd_asserts.sv
tb_sdcmd.sv

//--- Makefile
# Verilator build, run, lint and clean for the SD command line host

VERILATOR ?= verilator
TOP       ?= tb_sdcmd
FILELIST  ?= sdcmd.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_sdcmd.sv
/*
 * Testbench for the SD command line host
 * Clock, reset, card model on the command line, random commands
 * Immediate checks per response and per test result lines
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sdcmd;

    logic                           clk = 1'b0;
    logic                           nrst = 1'b0;
    logic [sdcmd_pkg::CLKDIV_W-1:0] clkdiv = 8'd2;
    logic [sdcmd_pkg::WDOG_W-1:0]   watchdog = 16'd50;
    logic                           cmd_set_low = 1'b0;
    logic                           req_valid = 1'b0;
    sdcmd_pkg::sdcmd_req_t          req = '0;
    logic                           resp_ready = 1'b0;
    logic                           clear_cmderr = 1'b0;
    logic                           cmd_in = 1'b1;

    logic                           req_ready;
    logic                           resp_valid;
    sdcmd_pkg::sdcmd_resp_t         resp;
    sdcmd_pkg::cmdstate_e           cmdstate;
    sdcmd_pkg::cmderr_e             cmderr;
    logic                           sclk;
    logic                           cmd_out;
    logic                           cmd_dir;

    // Card model state
    logic        card_armed = 1'b1;
    logic        card_silent = 1'b0;
    logic        card_bad_stop = 1'b0;
    logic [31:0] card_reg = '0;
    logic [47:0] card_frame = '0;
    logic [47:0] rx_shift = '0;
    logic [5:0]  rx_cnt = '0;
    logic [47:0] tx_shift = '1;
    logic        sclk_prev = 1'b0;

    int err_cnt = 0;
    int test_cnt = 0;
    int failed_tests = 0;
    int last_fails = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    sdcmd_top i_sdcmd_top (
        .i_clk          (clk),
        .i_nrst         (nrst),
        .i_clkdiv       (clkdiv),
        .i_watchdog     (watchdog),
        .i_cmd_set_low  (cmd_set_low),
        .i_req_valid    (req_valid),
        .i_req          (req),
        .o_req_ready    (req_ready),
        .o_resp_valid   (resp_valid),
        .o_resp         (resp),
        .i_resp_ready   (resp_ready),
        .i_clear_cmderr (clear_cmderr),
        .o_cmdstate     (cmdstate),
        .o_cmderr       (cmderr),
        .o_sclk         (sclk),
        .o_cmd          (cmd_out),
        .o_cmd_dir      (cmd_dir),
        .i_cmd          (cmd_in)
    );

    always #5 clk = ~clk;

    // SD CRC7, generator x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    // 48-bit frame: start, transmission bit, index, body, CRC7, end bit
    function automatic logic [47:0] cmd_frame(input logic trans, input logic [5:0] idx,
                                              input logic [31:0] body, input logic end_bit);
        return {1'b0, trans, idx, body, crc7_of({1'b0, trans, idx, body}), end_bit};
    endfunction

    function automatic int total_fails();
        return err_cnt + i_sdcmd_top.i_asserts.fail_cnt;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (total_fails() == last_fails) begin
            $display("test %0d %s: passed", test_cnt, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed", test_cnt, name);
        end
        last_fails = total_fails();
    endtask

    task automatic wait_sclk_falls(input int n);
        int   seen;
        logic prev;
        seen = 0;
        prev = sclk;
        while (seen < n) begin
            @(posedge clk);
            if (prev && !sclk) begin
                seen++;
            end
            prev = sclk;
        end
    endtask

    task automatic clear_error();
        clear_cmderr <= 1'b1;
        @(posedge clk);
        clear_cmderr <= 1'b0;
        do @(posedge clk); while (!req_ready);
        check_eq("o_cmderr", 64'(cmderr), 64'(sdcmd_pkg::CMDERR_NONE));
    endtask

    // One request, its response held for ack_delay cycles, then acknowledged
    task automatic run_command(input int unsigned ack_delay, input sdcmd_pkg::cmderr_e exp_err);
        logic [5:0]             idx;
        logic [31:0]            arg;
        logic [31:0]            reg_val;
        logic [6:0]             exp_crc;
        sdcmd_pkg::resp_type_e  rtype;
        sdcmd_pkg::sdcmd_resp_t held;
        idx = 6'($urandom);
        arg = $urandom;
        reg_val = $urandom;
        rtype = sdcmd_pkg::resp_type_e'(2'($urandom_range(2)));
        exp_crc = crc7_of({2'b00, idx, reg_val});
        card_reg <= reg_val;
        req <= '{idx: idx, arg: arg, rtype: rtype};
        req_valid <= 1'b1;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        do @(posedge clk); while (!resp_valid);
        held = resp;
        check_eq("o_cmderr", 64'(cmderr), 64'(exp_err));
        check_eq("o_resp.rtype", 64'(resp.rtype), 64'(rtype));
        check_eq("o_resp.rsvd", 64'(resp.rsvd), 64'h0);
        check_eq("host frame", 64'(card_frame), 64'(cmd_frame(1'b1, idx, arg, 1'b1)));
        if (exp_err != sdcmd_pkg::CMDERR_NO_RESPONSE) begin
            check_eq("o_resp.cmd", 64'(resp.cmd), 64'(idx));
            check_eq("o_resp.card_reg", 64'(resp.card_reg), 64'(reg_val));
            check_eq("o_resp.crc7_rx", 64'(resp.crc7_rx), 64'(exp_crc));
            check_eq("o_resp.crc7_calc", 64'(resp.crc7_calc), 64'(exp_crc));
        end
        repeat (ack_delay) begin
            @(posedge clk);
            check_eq("o_resp_valid", 64'(resp_valid), 64'h1);
            check_eq("o_resp", 64'(resp), 64'(held));
        end
        resp_ready <= 1'b1;
        @(posedge clk);
        resp_ready <= 1'b0;
        @(posedge clk);
        check_eq("o_resp_valid", 64'(resp_valid), 64'h0);
    endtask

    // Card: samples the host on rising SD clock, answers on falling SD clock
    always @(posedge clk) begin
        logic [47:0] frame;
        sclk_prev <= sclk;
        frame = {rx_shift[46:0], cmd_out};
        if (sclk && !sclk_prev && cmd_dir == sdcmd_pkg::DIR_OUTPUT) begin
            if (rx_cnt != '0) begin
                rx_shift <= frame;
                if (rx_cnt == 6'd47) begin
                    rx_cnt <= '0;
                    card_frame <= frame;
                    if (!card_silent) begin
                        tx_shift <= cmd_frame(1'b0, frame[45:40], card_reg, !card_bad_stop);
                    end
                end else begin
                    rx_cnt <= rx_cnt + 6'd1;
                end
            end else if (card_armed && !cmd_out) begin
                rx_shift <= '0;
                rx_cnt <= 6'd1;
            end
        end else if (!sclk && sclk_prev) begin
            cmd_in <= tx_shift[47];
            tx_shift <= {tx_shift[46:0], 1'b1};
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hf115));
        // 5 tests of up to 120 SD clocks each, with a margin of 2
        cycle_limit = 5 * 120 * 2 * int'(clkdiv) * 2;
        repeat (10) @(posedge clk);
        nrst <= 1'b1;
        check_eq("crc7_of CMD0", 64'(crc7_of(40'h40_0000_0000)), 64'h4a);

        repeat (2) run_command(0, sdcmd_pkg::CMDERR_NONE);
        finish_test("frame_and_response");

        repeat (2) run_command($urandom_range(20), sdcmd_pkg::CMDERR_NONE);
        finish_test("back_pressure");

        watchdog <= 16'd5;
        card_silent <= 1'b1;
        run_command(0, sdcmd_pkg::CMDERR_NO_RESPONSE);
        repeat (40) begin
            @(posedge clk);
            check_eq("o_req_ready", 64'(req_ready), 64'h0);
        end
        clear_error();
        watchdog <= 16'd50;
        card_silent <= 1'b0;
        finish_test("no_response");

        card_bad_stop <= 1'b1;
        run_command(0, sdcmd_pkg::CMDERR_WRONG_RESP_STOPBIT);
        card_bad_stop <= 1'b0;
        clear_error();
        finish_test("wrong_stop_bit");

        // Line held low in IDLE, card ignores it
        card_armed <= 1'b0;
        cmd_set_low <= 1'b1;
        wait_sclk_falls(2);
        check_eq("o_cmd", 64'(cmd_out), 64'h0);
        check_eq("o_cmd_dir", 64'(cmd_dir), 64'(sdcmd_pkg::DIR_OUTPUT));
        cmd_set_low <= 1'b0;
        wait_sclk_falls(2);
        check_eq("o_cmd", 64'(cmd_out), 64'h1);
        finish_test("power_up_hold");

        $display("%0d tests run, %0d failed, %0d failed checks",
                 test_cnt, failed_tests, total_fails());
        if (total_fails() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sdcmd_asserts.sv
/*
 * Concurrent protocol assertions for the SD command line host
 * Strobe timing, error blocking, response hold, line direction
 */
`timescale 1ns/1ps
`default_nettype none

module sdcmd_asserts (
    input logic                   i_clk,
    input logic                   i_nrst,
    input logic                   i_sclk,
    input logic                   i_sclk_posedge,
    input logic                   i_sclk_negedge,
    input logic                   i_req_ready,
    input logic                   i_resp_valid,
    input logic                   i_resp_ready,
    input sdcmd_pkg::sdcmd_resp_t i_resp,
    input sdcmd_pkg::cmdstate_e   i_cmdstate,
    input sdcmd_pkg::cmderr_e     i_cmderr,
    input logic                   i_cmd_dir
);

    // Number of assertion failures so far
    int fail_cnt = 0;

    // Each strobe marks the matching SD clock edge, never both at once
    strobe_edge: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(i_sclk_posedge && i_sclk_negedge)
        && (i_sclk_posedge == (i_sclk && !$past(i_sclk)))
        && (i_sclk_negedge == (!i_sclk && $past(i_sclk))))
        else begin
            $error("SD clock strobes do not match the clock edges");
            fail_cnt++;
        end

    ready_blocked: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req_ready |-> (i_cmderr == sdcmd_pkg::CMDERR_NONE))
        else begin
            $error("Request ready while an error is latched");
            fail_cnt++;
        end

    // Response holds until the host takes it
    resp_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_resp_valid && !i_resp_ready) |=> $stable(i_resp))
        else begin
            $error("Response changed while waiting for ready");
            fail_cnt++;
        end

    dir_out: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_cmdstate < sdcmd_pkg::CMDSTATE_RESP_WAIT) |-> (i_cmd_dir == sdcmd_pkg::DIR_OUTPUT))
        else begin
            $error("Command line not driven in a request state");
            fail_cnt++;
        end

endmodule

bind sdcmd_top sdcmd_asserts i_asserts (
    .i_clk          (i_clk),
    .i_nrst         (i_nrst),
    .i_sclk         (o_sclk),
    .i_sclk_posedge (sclk_posedge),
    .i_sclk_negedge (sclk_negedge),
    .i_req_ready    (o_req_ready),
    .i_resp_valid   (o_resp_valid),
    .i_resp_ready   (i_resp_ready),
    .i_resp         (o_resp),
    .i_cmdstate     (o_cmdstate),
    .i_cmderr       (o_cmderr),
    .i_cmd_dir      (o_cmd_dir)
);

`default_nettype wire

//--- sdcmd_top.sv
/*
 * SD command line host top level
 * SD clock divider, CRC7 unit and command FSM
 */
`timescale 1ns/1ps
`default_nettype none

module sdcmd_top (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic [sdcmd_pkg::CLKDIV_W-1:0] i_clkdiv,
    input  logic [sdcmd_pkg::WDOG_W-1:0]   i_watchdog,
    input  logic                           i_cmd_set_low,
    input  logic                           i_req_valid,
    input  sdcmd_pkg::sdcmd_req_t          i_req,
    output logic                           o_req_ready,
    output logic                           o_resp_valid,
    output sdcmd_pkg::sdcmd_resp_t         o_resp,
    input  logic                           i_resp_ready,
    input  logic                           i_clear_cmderr,
    output sdcmd_pkg::cmdstate_e           o_cmdstate,
    output sdcmd_pkg::cmderr_e             o_cmderr,
    output logic                           o_sclk,
    output logic                           o_cmd,
    output logic                           o_cmd_dir,
    input  logic                           i_cmd
);

    logic                        sclk_posedge;
    logic                        sclk_negedge;
    logic                        crc7_clear;
    logic                        crc7_next;
    logic                        crc7_dat;
    logic [sdcmd_pkg::CRC7_W-1:0] crc7;

    sdcmd_sclk_gen i_sclk_gen (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_clkdiv       (i_clkdiv),
        .o_sclk         (o_sclk),
        .o_sclk_posedge (sclk_posedge),
        .o_sclk_negedge (sclk_negedge)
    );

    sdcmd_crc7 i_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc7_clear),
        .i_next  (crc7_next),
        .i_dat   (crc7_dat),
        .o_crc7  (crc7)
    );

    sdcmd_cmd_transmitter i_cmd_transmitter (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_sclk_posedge (sclk_posedge),
        .i_sclk_negedge (sclk_negedge),
        .i_cmd          (i_cmd),
        .o_cmd          (o_cmd),
        .o_cmd_dir      (o_cmd_dir),
        .i_watchdog     (i_watchdog),
        .i_cmd_set_low  (i_cmd_set_low),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .o_req_ready    (o_req_ready),
        .i_crc7         (crc7),
        .o_crc7_clear   (crc7_clear),
        .o_crc7_next    (crc7_next),
        .o_crc7_dat     (crc7_dat),
        .o_resp_valid   (o_resp_valid),
        .o_resp         (o_resp),
        .i_resp_ready   (i_resp_ready),
        .i_clear_cmderr (i_clear_cmderr),
        .o_cmdstate     (o_cmdstate),
        .o_cmderr       (o_cmderr)
    );

endmodule

`default_nettype wire

//--- sdcmd_cmd_transmitter.sv
/*
 * SD command line FSM
 * Serializes the 48-bit command frame, waits for the response with a watchdog
 * and captures the 48-bit R1/R3/R6 response with error reporting
 */
`timescale 1ns/1ps
`default_nettype none

module sdcmd_cmd_transmitter (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_sclk_posedge,
    input  logic                          i_sclk_negedge,
    input  logic                          i_cmd,
    output logic                          o_cmd,
    output logic                          o_cmd_dir,
    input  logic [sdcmd_pkg::WDOG_W-1:0]  i_watchdog,
    input  logic                          i_cmd_set_low,
    input  logic                          i_req_valid,
    input  sdcmd_pkg::sdcmd_req_t         i_req,
    output logic                          o_req_ready,
    input  logic [sdcmd_pkg::CRC7_W-1:0]  i_crc7,
    output logic                          o_crc7_clear,
    output logic                          o_crc7_next,
    output logic                          o_crc7_dat,
    output logic                          o_resp_valid,
    output sdcmd_pkg::sdcmd_resp_t        o_resp,
    input  logic                          i_resp_ready,
    input  logic                          i_clear_cmderr,
    output sdcmd_pkg::cmdstate_e          o_cmdstate,
    output sdcmd_pkg::cmderr_e            o_cmderr
);

    localparam int FW = sdcmd_pkg::FRAME_W;
    localparam int CW = sdcmd_pkg::BITCNT_W;

    typedef struct packed {
        sdcmd_pkg::cmdstate_e   cmdstate;
        sdcmd_pkg::cmderr_e     cmderr;
        logic [FW-1:0]          cmdshift;
        logic [CW-1:0]          cmdbitcnt;
        logic [sdcmd_pkg::WDOG_W-1:0] watchdog;
        sdcmd_pkg::resp_type_e  rtype;
        logic                   resp_valid;
        sdcmd_pkg::sdcmd_resp_t resp;
    } tx_regs_t;

    tx_regs_t r;
    tx_regs_t rin;

    logic driving;
    logic v_req_ready;
    logic v_crc7_next;
    logic v_crc7_clear;

    assign driving = (r.cmdstate < sdcmd_pkg::CMDSTATE_RESP_WAIT)
                     || (r.cmdstate == sdcmd_pkg::CMDSTATE_PAUSE);

    always_comb begin
        tx_regs_t v;

        v = r;
        v_req_ready = 1'b0;
        v_crc7_next = 1'b0;
        v_crc7_clear = 1'b0;

        if (i_clear_cmderr) begin
            v.cmderr = sdcmd_pkg::CMDERR_NONE;
        end
        if (i_resp_ready) begin
            v.resp_valid = 1'b0;
        end

        if (i_sclk_negedge) begin
            // Request side, MSB of the shift register is on the line
            case (r.cmdstate)
                sdcmd_pkg::CMDSTATE_IDLE: begin
                    v.cmdshift = i_cmd_set_low ? '0 : '1;
                    v_crc7_clear = 1'b1;
                    if (r.cmderr == sdcmd_pkg::CMDERR_NONE) begin
                        v_req_ready = 1'b1;
                        if (i_req_valid) begin
                            v.cmdshift = {1'b0, 1'b1, i_req.idx, i_req.arg};
                            v.rtype = i_req.rtype;
                            v.cmdbitcnt = CW'(FW - 1);
                            v_crc7_clear = 1'b0;
                            v_crc7_next = 1'b1;
                            v.cmdstate = sdcmd_pkg::CMDSTATE_REQ_CONTENT;
                        end
                    end
                end
                sdcmd_pkg::CMDSTATE_REQ_CONTENT: begin
                    if (r.cmdbitcnt != '0) begin
                        v.cmdshift = {r.cmdshift[FW-2:0], 1'b1};
                        v.cmdbitcnt = r.cmdbitcnt - 1'b1;
                        v_crc7_next = 1'b1;
                    end else begin
                        // CRC covers all 40 content bits by now, end bit follows it
                        v.cmdshift = {i_crc7, {(FW - sdcmd_pkg::CRC7_W){1'b1}}};
                        v.cmdbitcnt = CW'(sdcmd_pkg::CRC7_W - 1);
                        v_crc7_clear = 1'b1;
                        v.cmdstate = sdcmd_pkg::CMDSTATE_REQ_CRC7;
                    end
                end
                sdcmd_pkg::CMDSTATE_REQ_CRC7: begin
                    v.cmdshift = {r.cmdshift[FW-2:0], 1'b1};
                    if (r.cmdbitcnt != '0) begin
                        v.cmdbitcnt = r.cmdbitcnt - 1'b1;
                    end else begin
                        v.cmdstate = sdcmd_pkg::CMDSTATE_REQ_STOPBIT;
                    end
                end
                sdcmd_pkg::CMDSTATE_REQ_STOPBIT: begin
                    v.watchdog = i_watchdog;
                    v.cmdstate = sdcmd_pkg::CMDSTATE_RESP_WAIT;
                end
                sdcmd_pkg::CMDSTATE_PAUSE: begin
                    v_crc7_clear = 1'b1;
                    if (r.cmdbitcnt != '0) begin
                        v.cmdbitcnt = r.cmdbitcnt - 1'b1;
                    end else begin
                        v.cmdstate = sdcmd_pkg::CMDSTATE_IDLE;
                    end
                end
                default: begin
                end
            endcase
        end else if (i_sclk_posedge) begin
            // Response side, card bits sampled on the rising SD clock
            case (r.cmdstate)
                sdcmd_pkg::CMDSTATE_RESP_WAIT: begin
                    v.watchdog = r.watchdog - 1'b1;
                    if (!i_cmd) begin
                        v_crc7_next = 1'b1;
                        v.cmdstate = sdcmd_pkg::CMDSTATE_RESP_TRANSBIT;
                    end else if (r.watchdog == '0) begin
                        v.cmderr = sdcmd_pkg::CMDERR_NO_RESPONSE;
                        v.resp.rtype = r.rtype;
                        v.resp_valid = 1'b1;
                        v.cmdstate = sdcmd_pkg::CMDSTATE_IDLE;
                    end
                end
                sdcmd_pkg::CMDSTATE_RESP_TRANSBIT: begin
                    v_crc7_next = 1'b1;
                    if (!i_cmd) begin
                        v.cmdbitcnt = CW'(sdcmd_pkg::CMD_IDX_W - 1);
                        v.cmdstate = sdcmd_pkg::CMDSTATE_RESP_CMD_MIRROR;
                    end else begin
                        v.cmderr = sdcmd_pkg::CMDERR_WRONG_RESP_STARTBIT;
                        v.resp.rtype = r.rtype;
                        v.resp_valid = 1'b1;
                        v.cmdstate = sdcmd_pkg::CMDSTATE_IDLE;
                    end
                end
                sdcmd_pkg::CMDSTATE_RESP_CMD_MIRROR: begin
                    v_crc7_next = 1'b1;
                    v.resp.cmd = {r.resp.cmd[sdcmd_pkg::CMD_IDX_W-2:0], i_cmd};
                    if (r.cmdbitcnt != '0) begin
                        v.cmdbitcnt = r.cmdbitcnt - 1'b1;
                    end else begin
                        v.cmdbitcnt = CW'(sdcmd_pkg::CMD_ARG_W - 1);
                        v.cmdstate = sdcmd_pkg::CMDSTATE_RESP_REG;
                    end
                end
                sdcmd_pkg::CMDSTATE_RESP_REG: begin
                    v_crc7_next = 1'b1;
                    v.resp.card_reg = {r.resp.card_reg[sdcmd_pkg::CMD_ARG_W-2:0], i_cmd};
                    if (r.cmdbitcnt != '0) begin
                        v.cmdbitcnt = r.cmdbitcnt - 1'b1;
                    end else begin
                        v.cmdbitcnt = CW'(sdcmd_pkg::CRC7_W - 1);
                        v.cmdstate = sdcmd_pkg::CMDSTATE_RESP_CRC7;
                    end
                end
                sdcmd_pkg::CMDSTATE_RESP_CRC7: begin
                    // First CRC bit: the unit has absorbed all 40 response bits
                    if (r.cmdbitcnt == CW'(sdcmd_pkg::CRC7_W - 1)) begin
                        v.resp.crc7_calc = i_crc7;
                    end
                    v.resp.crc7_rx = {r.resp.crc7_rx[sdcmd_pkg::CRC7_W-2:0], i_cmd};
                    if (r.cmdbitcnt != '0) begin
                        v.cmdbitcnt = r.cmdbitcnt - 1'b1;
                    end else begin
                        v.cmdstate = sdcmd_pkg::CMDSTATE_RESP_STOPBIT;
                    end
                end
                sdcmd_pkg::CMDSTATE_RESP_STOPBIT: begin
                    if (!i_cmd) begin
                        v.cmderr = sdcmd_pkg::CMDERR_WRONG_RESP_STOPBIT;
                    end
                    v.resp.rtype = r.rtype;
                    v.resp_valid = 1'b1;
                    v.cmdbitcnt = CW'(2);
                    v.cmdstate = sdcmd_pkg::CMDSTATE_PAUSE;
                end
                default: begin
                end
            endcase
        end

        rin = v;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r <= '{
                cmdstate: sdcmd_pkg::CMDSTATE_IDLE,
                cmderr: sdcmd_pkg::CMDERR_NONE,
                cmdshift: '1,
                cmdbitcnt: '0,
                watchdog: '0,
                rtype: sdcmd_pkg::RESP_R1,
                resp_valid: 1'b0,
                resp: '0
            };
        end else begin
            r <= rin;
        end
    end

    assign o_cmd = r.cmdshift[FW-1];
    assign o_cmd_dir = driving ? sdcmd_pkg::DIR_OUTPUT : sdcmd_pkg::DIR_INPUT;
    assign o_req_ready = v_req_ready;
    assign o_crc7_clear = v_crc7_clear;
    assign o_crc7_next = v_crc7_next;
    // While driving, the CRC sees the bit being launched this strobe
    assign o_crc7_dat = driving ? rin.cmdshift[FW-1] : i_cmd;
    assign o_resp_valid = r.resp_valid;
    assign o_resp = r.resp;
    assign o_cmdstate = r.cmdstate;
    assign o_cmderr = r.cmderr;

endmodule

`default_nettype wire

//--- sdcmd_crc7.sv
/*
 * Serial CRC7 accumulator, polynomial x^7 + x^3 + 1
 */
`timescale 1ns/1ps
`default_nettype none

module sdcmd_crc7 (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_clear,
    input  logic                        i_next,
    input  logic                        i_dat,
    output logic [sdcmd_pkg::CRC7_W-1:0] o_crc7
);

    logic fb;

    assign fb = i_dat ^ o_crc7[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc7 <= '0;
        end else if (i_clear) begin
            o_crc7 <= '0;
        end else if (i_next) begin
            // Feedback taps at x^3 and x^0
            o_crc7 <= {o_crc7[5:3], o_crc7[2] ^ fb, o_crc7[1:0], fb};
        end
    end

endmodule

`default_nettype wire

//--- sdcmd_sclk_gen.sv
/*
 * SD clock generator
 * Programmable half-period divider with one-cycle rise and fall strobes
 */
`timescale 1ns/1ps
`default_nettype none

module sdcmd_sclk_gen (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic [sdcmd_pkg::CLKDIV_W-1:0] i_clkdiv,
    output logic                          o_sclk,
    output logic                          o_sclk_posedge,
    output logic                          o_sclk_negedge
);

    logic [sdcmd_pkg::CLKDIV_W-1:0] cnt;
    logic                           toggle;

    assign toggle = (cnt == '0);

    // Strobes are registered with the clock so they line up with the toggle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt <= '0;
            o_sclk <= 1'b0;
            o_sclk_posedge <= 1'b0;
            o_sclk_negedge <= 1'b0;
        end else begin
            o_sclk_posedge <= toggle & ~o_sclk;
            o_sclk_negedge <= toggle & o_sclk;
            if (toggle) begin
                // New divider value is taken here
                cnt <= i_clkdiv - 1'b1;
                o_sclk <= ~o_sclk;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sdcmd_pkg.sv
/*
 * Shared definitions for the SD command line controller
 * Widths, FSM state and error encodings, line direction values
 * Request and response structs
 */
`default_nettype none

package sdcmd_pkg;

    localparam int CMD_IDX_W = 6;
    localparam int CMD_ARG_W = 32;
    localparam int CRC7_W = 7;
    localparam int WDOG_W = 16;
    localparam int CLKDIV_W = 8;

    // Start and transmission bits plus index and argument
    localparam int FRAME_W = 2 + CMD_IDX_W + CMD_ARG_W;
    localparam int BITCNT_W = 6;
    localparam int RESP_RSVD_W = 2;

    // Command line direction
    localparam logic DIR_OUTPUT = 1'b0;
    localparam logic DIR_INPUT = 1'b1;

    // States below CMDSTATE_RESP_WAIT drive the line, as does CMDSTATE_PAUSE
    typedef enum logic [3:0] {
        CMDSTATE_IDLE,
        CMDSTATE_REQ_CONTENT,
        CMDSTATE_REQ_CRC7,
        CMDSTATE_REQ_STOPBIT,
        CMDSTATE_RESP_WAIT,
        CMDSTATE_RESP_TRANSBIT,
        CMDSTATE_RESP_CMD_MIRROR,
        CMDSTATE_RESP_REG,
        CMDSTATE_RESP_CRC7,
        CMDSTATE_RESP_STOPBIT,
        CMDSTATE_PAUSE
    } cmdstate_e;

    typedef enum logic [3:0] {
        CMDERR_NONE,
        CMDERR_NO_RESPONSE,
        CMDERR_WRONG_RESP_STARTBIT,
        CMDERR_WRONG_RESP_STOPBIT
    } cmderr_e;

    // 48-bit response formats only
    typedef enum logic [1:0] {
        RESP_R1,
        RESP_R3,
        RESP_R6
    } resp_type_e;

    typedef struct packed {
        logic [CMD_IDX_W-1:0] idx;
        logic [CMD_ARG_W-1:0] arg;
        resp_type_e rtype;
    } sdcmd_req_t;

    // Card status (R1), OCR (R3) or RCA (R6) in card_reg
    typedef struct packed {
        logic [CMD_IDX_W-1:0] cmd;
        logic [CMD_ARG_W-1:0] card_reg;
        logic [CRC7_W-1:0] crc7_rx;
        logic [CRC7_W-1:0] crc7_calc;
        resp_type_e rtype;
        logic [RESP_RSVD_W-1:0] rsvd;
    } sdcmd_resp_t;

endpackage

`default_nettype wire
